// ==== tb.f ====
+incdir+tests
hdl/rob_pkg.sv
hdl/rob_entry.sv
hdl/rob_alloc.sv
hdl/rob_wb_decode.sv
hdl/rob_commit.sv
hdl/rob_top.sv
tests/rob_tb.sv

// ==== Makefile ====
# Verilator flow for the reorder buffer testbench

TOP       ?= rob_tb
SEED_LOG  ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --assert
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1 || true
	@if grep -qx "TB PASSED" $(SEED_LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(SEED_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// ==== tests/rob_tb_model.svh ====
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// one record per live instruction, oldest first
typedef struct packed {
    rob_payload_t payload;
    rob_ptr_t     ptr;
    logic         complete;
    logic         skip;
} rob_rec_t;

rob_rec_t model_q[$];
rob_ptr_t model_enq_ptr;
rob_ptr_t model_deq_ptr;

// index wraps at the last entry, flag toggles on the wrap
function automatic rob_ptr_t ptr_inc(input rob_ptr_t p);
    rob_ptr_t r;
    r = p;
    if (p.idx == rob_idx_t'(rob_size - 1)) begin
        r.idx  = '0;
        r.flag = ~p.flag;
    end else begin
        r.idx = p.idx + rob_idx_t'(1);
    end
    return r;
endfunction

function automatic void model_reset();
    model_q.delete();
    model_enq_ptr = '0;
    model_deq_ptr = '0;
endfunction

// retire count this cycle, in order from the oldest
function automatic int predict_commits();
    int n;
    n = 0;
    if (model_q.size() > 0 && model_q[0].complete) begin
        n = 1;
        if (model_q.size() > 1 && model_q[1].complete) begin
            n = 2;
        end
    end
    return n;
endfunction

function automatic void mark_wb(input rob_wb_t w, input logic sk);
    foreach (model_q[i]) begin
        if (w.valid && model_q[i].ptr == w.ptr) begin
            model_q[i].complete = 1'b1;
            if (sk) begin
                model_q[i].skip = 1'b1;
            end
        end
    end
endfunction

function automatic void push_enq(input rob_enq_t e);
    rob_rec_t rec;
    rec.payload = '{pc: e.pc, instr: e.instr, lrd: e.lrd, prd: e.prd, old_prd: e.old_prd};
    rec.ptr      = model_enq_ptr;
    rec.complete = ~e.need_to_wb;
    rec.skip     = 1'b0;
    model_q.push_back(rec);
    model_enq_ptr = ptr_inc(model_enq_ptr);
endfunction

// effect of one clock edge on the model
task automatic model_step(input rob_enq_t e0, input rob_enq_t e1, input rob_wb_t w0,
                          input rob_wb_t w1, input rob_wb_t w2, input logic mmio,
                          input rob_redirect_t rd);
    int n;
    int keep;
    n = predict_commits();
    repeat (n) begin
        void'(model_q.pop_front());
        model_deq_ptr = ptr_inc(model_deq_ptr);
    end
    mark_wb(w0, 1'b0);
    mark_wb(w1, mmio);
    mark_wb(w2, 1'b0);
    if (rd.valid) begin
        // keep up to and including the redirect pointer
        keep = 0;
        foreach (model_q[i]) begin
            if (model_q[i].ptr == rd.ptr) begin
                keep = i + 1;
            end
        end
        while (model_q.size() > keep) begin
            void'(model_q.pop_back());
        end
        model_enq_ptr = ptr_inc(rd.ptr);
    end else begin
        if (e0.valid) begin
            push_enq(e0);
        end
        if (e1.valid) begin
            push_enq(e1);
        end
    end
endtask

`endif

// ==== tests/rob_tb.sv ====
`timescale 1ns/10ps

module rob_tb;
    import rob_pkg::*;

    localparam int num_cycles = 4000;
    localparam int rand_seed  = 30370;

    logic          clock;
    logic          reset_n;
    rob_enq_t      enq0;
    rob_enq_t      enq1;
    rob_wb_t       wb0;
    rob_wb_t       wb1;
    rob_wb_t       wb2;
    logic          wb1_mmio;
    rob_redirect_t redirect;
    rob_ptr_t      enq_ptr;
    logic          full;
    rob_count_t    count;
    rob_commit_t   commit0;
    rob_commit_t   commit1;

    // stimulus on the DUT inputs, applied to the model at the edge that samples it
    rob_enq_t      nx_enq0;
    rob_enq_t      nx_enq1;
    rob_wb_t       nx_wb [3];
    logic          nx_mmio;
    rob_redirect_t nx_redirect;

    `include "rob_tb_model.svh"

    rob_top dut0 (
        .clock    (clock),
        .reset_n  (reset_n),
        .enq0     (enq0),
        .enq1     (enq1),
        .enq_ptr  (enq_ptr),
        .full     (full),
        .count    (count),
        .wb0      (wb0),
        .wb1      (wb1),
        .wb2      (wb2),
        .wb1_mmio (wb1_mmio),
        .commit0  (commit0),
        .commit1  (commit1),
        .redirect (redirect)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("[ERROR] %0t %s expected %0h actual %0h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_commit(input string tag, input rob_rec_t r, input rob_commit_t c);
        check_field({tag, ".pc"}, 64'(r.payload.pc), 64'(c.pc));
        check_field({tag, ".instr"}, 64'(r.payload.instr), 64'(c.instr));
        check_field({tag, ".lrd"}, 64'(r.payload.lrd), 64'(c.lrd));
        check_field({tag, ".prd"}, 64'(r.payload.prd), 64'(c.prd));
        check_field({tag, ".old_prd"}, 64'(r.payload.old_prd), 64'(c.old_prd));
        check_field({tag, ".ptr"}, 64'(r.ptr), 64'(c.ptr));
        check_field({tag, ".skip"}, 64'(r.skip), 64'(c.skip));
    endtask

    task automatic check_outputs();
        int n;
        n = predict_commits();
        assert (commit0.valid || !commit1.valid) else begin
            abort_run("commit1 is valid while commit0 is not");
        end
        check_field("commit0.valid", 64'(n > 0), 64'(commit0.valid));
        check_field("commit1.valid", 64'(n > 1), 64'(commit1.valid));
        if (n > 0) begin
            check_commit("commit0", model_q[0], commit0);
        end
        if (n > 1) begin
            check_commit("commit1", model_q[1], commit1);
        end
        check_field("enq_ptr", 64'(model_enq_ptr), 64'(enq_ptr));
        check_field("count", 64'(model_q.size()), 64'(count));
        // full while fewer than two entries are free
        check_field("full", 64'((rob_size - model_q.size()) < 2), 64'(full));
    endtask

    function automatic rob_enq_t random_instr();
        rob_enq_t e;
        e.valid      = 1'b1;
        e.pc         = pc_t'({$urandom, $urandom});
        e.instr      = instr_t'($urandom);
        e.lrd        = lreg_t'($urandom);
        e.prd        = preg_t'($urandom);
        e.old_prd    = preg_t'($urandom);
        e.need_to_wb = ($urandom_range(0, 3) != 0);
        return e;
    endfunction

    task automatic pick_stimulus();
        int open_q[$];
        int n_enq;
        int n_com;
        int pick;
        int lo;
        nx_enq0 = '0;
        nx_enq1 = '0;
        if (model_q.size() <= rob_size - 2) begin
            n_enq = $urandom_range(0, 2);
            if (n_enq > 0) begin
                nx_enq0 = random_instr();
            end
            if (n_enq > 1) begin
                nx_enq1 = random_instr();
            end
        end
        // each port gets a distinct incomplete entry
        foreach (model_q[i]) begin
            if (!model_q[i].complete) begin
                open_q.push_back(i);
            end
        end
        for (int p = 0; p < 3; p++) begin
            nx_wb[p] = '0;
            if (open_q.size() > 0 && $urandom_range(0, 1) == 1) begin
                pick            = $urandom_range(0, open_q.size() - 1);
                nx_wb[p].valid  = 1'b1;
                nx_wb[p].ptr    = model_q[open_q[pick]].ptr;
                open_q.delete(pick);
            end
        end
        nx_mmio = nx_wb[1].valid && ($urandom_range(0, 3) == 0);
        // redirect never lands below an entry retiring in the same cycle
        nx_redirect = '0;
        n_com = predict_commits();
        lo    = (n_com > 0) ? n_com - 1 : 0;
        if (model_q.size() > lo && $urandom_range(0, 99) == 0) begin
            pick               = $urandom_range(lo, model_q.size() - 1);
            nx_redirect.valid  = 1'b1;
            nx_redirect.ptr    = model_q[pick].ptr;
        end
    endtask

    initial begin
        void'($urandom(rand_seed));
        reset_n     = 1'b0;
        enq0        = '0;
        enq1        = '0;
        wb0         = '0;
        wb1         = '0;
        wb2         = '0;
        wb1_mmio    = 1'b0;
        redirect    = '0;
        nx_enq0     = '0;
        nx_enq1     = '0;
        nx_wb       = '{default: '0};
        nx_mmio     = 1'b0;
        nx_redirect = '0;
        model_reset();
        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(negedge clock);
            check_outputs();
            @(posedge clock);
            // the DUT has just sampled the previous stimulus
            model_step(nx_enq0, nx_enq1, nx_wb[0], nx_wb[1], nx_wb[2], nx_mmio, nx_redirect);
            pick_stimulus();
            enq0     <= nx_enq0;
            enq1     <= nx_enq1;
            wb0      <= nx_wb[0];
            wb1      <= nx_wb[1];
            wb2      <= nx_wb[2];
            wb1_mmio <= nx_mmio;
            redirect <= nx_redirect;
        end
        @(negedge clock);
        check_outputs();
        $display("TB PASSED");
        $finish;
    end

    // twice the length of the stimulus run
    initial begin
        #(2 * num_cycles * 20);
        abort_run("the run timed out before all cycles completed");
    end

endmodule

// ==== hdl/rob_top.sv ====
`timescale 1ns/10ps

module rob_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  rob_pkg::rob_enq_t      enq0,
    input  rob_pkg::rob_enq_t      enq1,
    output rob_pkg::rob_ptr_t      enq_ptr,
    output logic                   full,
    output rob_pkg::rob_count_t    count,
    input  rob_pkg::rob_wb_t       wb0,
    input  rob_pkg::rob_wb_t       wb1,
    input  rob_pkg::rob_wb_t       wb2,
    input  logic                   wb1_mmio,
    output rob_pkg::rob_commit_t   commit0,
    output rob_pkg::rob_commit_t   commit1,
    input  rob_pkg::rob_redirect_t redirect
);
    import rob_pkg::*;

    logic [rob_size-1:0] enq_sel0;
    logic [rob_size-1:0] enq_sel1;
    logic [rob_size-1:0] flush;
    logic [rob_size-1:0] wb_done;
    logic [rob_size-1:0] wb_skip;
    logic [rob_size-1:0] entry_ready;
    logic [rob_size-1:0] entry_skip;
    logic [rob_size-1:0] go_commit;
    rob_payload_t        entry_payload [rob_size];
    rob_ptr_t            deq_ptr;

    rob_alloc u_alloc (
        .clock      (clock),
        .reset_n    (reset_n),
        .enq0_valid (enq0.valid),
        .enq1_valid (enq1.valid),
        .redirect   (redirect),
        .deq_ptr    (deq_ptr),
        .enq_sel0   (enq_sel0),
        .enq_sel1   (enq_sel1),
        .flush      (flush),
        .enq_ptr    (enq_ptr),
        .count      (count),
        .full       (full)
    );

    rob_wb_decode u_wb_decode (
        .wb0      (wb0),
        .wb1      (wb1),
        .wb2      (wb2),
        .wb1_mmio (wb1_mmio),
        .wb_done  (wb_done),
        .wb_skip  (wb_skip)
    );

    for (genvar i = 0; i < rob_size; i++) begin : g_entry
        rob_entry u_entry (
            .clock         (clock),
            .reset_n       (reset_n),
            .enq_sel       ({enq_sel1[i], enq_sel0[i]}),
            .enq0          (enq0),
            .enq1          (enq1),
            .wb_done       (wb_done[i]),
            .wb_skip       (wb_skip[i]),
            .flush         (flush[i]),
            .commit        (go_commit[i]),
            .entry_ready   (entry_ready[i]),
            .entry_payload (entry_payload[i]),
            .entry_skip    (entry_skip[i])
        );
    end

    rob_commit u_commit (
        .clock         (clock),
        .reset_n       (reset_n),
        .entry_ready   (entry_ready),
        .entry_payload (entry_payload),
        .entry_skip    (entry_skip),
        .go_commit     (go_commit),
        .deq_ptr       (deq_ptr),
        .commit0       (commit0),
        .commit1       (commit1)
    );

endmodule

// ==== hdl/rob_commit.sv ====
`timescale 1ns/10ps

module rob_commit (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [rob_pkg::rob_size-1:0] entry_ready,
    input  rob_pkg::rob_payload_t        entry_payload [rob_pkg::rob_size],
    input  logic [rob_pkg::rob_size-1:0] entry_skip,
    output logic [rob_pkg::rob_size-1:0] go_commit,
    output rob_pkg::rob_ptr_t            deq_ptr,
    output rob_pkg::rob_commit_t         commit0,
    output rob_pkg::rob_commit_t         commit1
);
    import rob_pkg::*;

    rob_idx_t     head_idx;
    rob_idx_t     next_idx;
    rob_ptr_t     next_ptr;
    logic         take0;
    logic         take1;
    logic [1:0]   deq_num;
    rob_payload_t head_pl;
    rob_payload_t next_pl;

    assign head_idx = deq_ptr.idx;
    assign next_idx = deq_ptr.idx + rob_idx_t'(1);
    assign next_ptr = deq_ptr + rob_ptr_t'(1);

    // strictly in order, second only behind the first
    assign take0 = entry_ready[head_idx];
    assign take1 = take0 & entry_ready[next_idx];

    always_comb begin
        for (int i = 0; i < rob_size; i++) begin
            go_commit[i] = (take0 && (head_idx == rob_idx_t'(i)))
                || (take1 && (next_idx == rob_idx_t'(i)));
        end
    end

    assign deq_num = {1'b0, take0} + {1'b0, take1};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            deq_ptr <= '0;
        end else begin
            deq_ptr <= deq_ptr + rob_ptr_t'(deq_num);
        end
    end

    assign head_pl = entry_payload[head_idx];
    assign next_pl = entry_payload[next_idx];

    assign commit0 = '{
        valid:   take0,
        pc:      head_pl.pc,
        instr:   head_pl.instr,
        lrd:     head_pl.lrd,
        prd:     head_pl.prd,
        old_prd: head_pl.old_prd,
        ptr:     deq_ptr,
        skip:    entry_skip[head_idx]
    };

    assign commit1 = '{
        valid:   take1,
        pc:      next_pl.pc,
        instr:   next_pl.instr,
        lrd:     next_pl.lrd,
        prd:     next_pl.prd,
        old_prd: next_pl.old_prd,
        ptr:     next_ptr,
        skip:    entry_skip[next_idx]
    };

endmodule

// ==== hdl/rob_wb_decode.sv ====
`timescale 1ns/10ps

module rob_wb_decode (
    input  rob_pkg::rob_wb_t             wb0,
    input  rob_pkg::rob_wb_t             wb1,
    input  rob_pkg::rob_wb_t             wb2,
    input  logic                         wb1_mmio,
    output logic [rob_pkg::rob_size-1:0] wb_done,
    output logic [rob_pkg::rob_size-1:0] wb_skip
);
    import rob_pkg::*;

    logic [rob_size-1:0] hit0;
    logic [rob_size-1:0] hit1;
    logic [rob_size-1:0] hit2;

    // one-hot decode per port
    always_comb begin
        for (int i = 0; i < rob_size; i++) begin
            hit0[i] = wb0.valid && (wb0.ptr.idx == rob_idx_t'(i));
            hit1[i] = wb1.valid && (wb1.ptr.idx == rob_idx_t'(i));
            hit2[i] = wb2.valid && (wb2.ptr.idx == rob_idx_t'(i));
        end
    end

    assign wb_done = hit0 | hit1 | hit2;

    // only the load/store port reaches MMIO space
    assign wb_skip = wb1_mmio ? hit1 : '0;

endmodule

// ==== hdl/rob_alloc.sv ====
`timescale 1ns/10ps

module rob_alloc (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enq0_valid,
    input  logic                         enq1_valid,
    input  rob_pkg::rob_redirect_t       redirect,
    input  rob_pkg::rob_ptr_t            deq_ptr,
    output logic [rob_pkg::rob_size-1:0] enq_sel0,
    output logic [rob_pkg::rob_size-1:0] enq_sel1,
    output logic [rob_pkg::rob_size-1:0] flush,
    output rob_pkg::rob_ptr_t            enq_ptr,
    output rob_pkg::rob_count_t          count,
    output logic                         full
);
    import rob_pkg::*;

    logic       enq_go0;
    logic       enq_go1;
    logic [1:0] enq_num;
    rob_idx_t   enq_idx1;
    rob_ptr_t   enq_ptr_nxt;
    rob_ptr_t   redirect_ptr_inc;
    rob_count_t flush_span;

    // enqueues in a redirect cycle are dropped
    assign enq_go0 = enq0_valid & ~redirect.valid;
    assign enq_go1 = enq1_valid & ~redirect.valid;
    assign enq_num = {1'b0, enq_go0} + {1'b0, enq_go1};

    assign enq_idx1 = enq_ptr.idx + rob_idx_t'(1);

    always_comb begin
        for (int i = 0; i < rob_size; i++) begin
            enq_sel0[i] = enq_go0 && (enq_ptr.idx == rob_idx_t'(i));
            enq_sel1[i] = enq_go1 && (enq_idx1 == rob_idx_t'(i));
        end
    end

    assign enq_ptr_nxt      = enq_ptr + rob_ptr_t'(enq_num);
    assign redirect_ptr_inc = redirect.ptr + rob_ptr_t'(1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
        end else if (redirect.valid) begin
            enq_ptr <= redirect_ptr_inc;
        end else begin
            enq_ptr <= enq_ptr_nxt;
        end
    end

    // entries from redirect.ptr up to enq_ptr, redirect.ptr itself included
    assign flush_span = enq_ptr - redirect.ptr;

    // flush what sits strictly after redirect.ptr in circular order
    always_comb begin
        for (int i = 0; i < rob_size; i++) begin
            flush[i] = redirect.valid
                && (rob_idx_t'(i) != redirect.ptr.idx)
                && ({1'b0, rob_idx_t'(rob_idx_t'(i) - redirect.ptr.idx)} < flush_span);
        end
    end

    // flags make a full buffer read 16, not 0
    assign count = enq_ptr - deq_ptr;
    assign full  = count > rob_count_t'(rob_size - 2);

    a_no_enq_full: assert property (@(posedge clock) disable iff (!reset_n)
        enq0_valid |-> !full)
        else $error("rob_alloc: enqueue while full");

    a_enq_order: assert property (@(posedge clock) disable iff (!reset_n)
        enq1_valid |-> enq0_valid)
        else $error("rob_alloc: slot 1 enqueue without slot 0");

endmodule

// ==== hdl/rob_entry.sv ====
`timescale 1ns/10ps

module rob_entry (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [1:0]            enq_sel,
    input  rob_pkg::rob_enq_t     enq0,
    input  rob_pkg::rob_enq_t     enq1,
    input  logic                  wb_done,
    input  logic                  wb_skip,
    input  logic                  flush,
    input  logic                  commit,
    output logic                  entry_ready,
    output rob_pkg::rob_payload_t entry_payload,
    output logic                  entry_skip
);
    import rob_pkg::*;

    logic         valid;
    logic         complete;
    logic         skip;
    logic         enq;
    rob_enq_t     slot;
    rob_payload_t payload;

    assign enq  = |enq_sel;
    // at most one slot targets this entry
    assign slot = enq_sel[1] ? enq1 : enq0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid    <= 1'b0;
            complete <= 1'b0;
            skip     <= 1'b0;
        end else begin
            if (commit || flush) begin
                valid <= 1'b0;
            end else if (enq) begin
                valid <= 1'b1;
            end

            if (enq) begin
                // no writeback expected, done at once
                complete <= ~slot.need_to_wb;
                skip     <= 1'b0;
            end else if (wb_done) begin
                complete <= 1'b1;
                if (wb_skip) begin
                    skip <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            payload <= '{
                pc:      slot.pc,
                instr:   slot.instr,
                lrd:     slot.lrd,
                prd:     slot.prd,
                old_prd: slot.old_prd
            };
        end
    end

    assign entry_ready   = valid & complete;
    assign entry_payload = payload;
    assign entry_skip    = skip;

    // allocator must only hand out free slots
    a_enq_free: assert property (@(posedge clock) disable iff (!reset_n) enq |-> !valid)
        else $error("rob_entry: enqueue into a live entry");

    a_wb_live: assert property (@(posedge clock) disable iff (!reset_n) wb_done |-> valid)
        else $error("rob_entry: writeback to a dead entry");

endmodule

// ==== hdl/rob_pkg.sv ====
package rob_pkg;

    // one supported configuration
    localparam int rob_size     = 16;
    localparam int rob_size_log = 4;

    typedef logic [63:0]             pc_t;
    typedef logic [31:0]             instr_t;
    typedef logic [4:0]              lreg_t;
    typedef logic [5:0]              preg_t;
    typedef logic [rob_size_log-1:0] rob_idx_t;
    // needs one extra bit to hold a full count of 16
    typedef logic [rob_size_log:0]   rob_count_t;

    // flag toggles on every wrap of idx
    typedef struct packed {
        logic     flag;
        rob_idx_t idx;
    } rob_ptr_t;

    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
        lreg_t  lrd;
        preg_t  prd;
        preg_t  old_prd;
        logic   need_to_wb;
    } rob_enq_t;

    typedef struct packed {
        logic     valid;
        rob_ptr_t ptr;
    } rob_wb_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        instr_t   instr;
        lreg_t    lrd;
        preg_t    prd;
        preg_t    old_prd;
        rob_ptr_t ptr;
        logic     skip;
    } rob_commit_t;

    typedef struct packed {
        logic     valid;
        rob_ptr_t ptr;
    } rob_redirect_t;

    // what a slot keeps after enqueue
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
        lreg_t  lrd;
        preg_t  prd;
        preg_t  old_prd;
    } rob_payload_t;

endpackage
